//--- st_io_consts.svh
`ifndef ST_IO_CONSTS_SVH
`define ST_IO_CONSTS_SVH

// Clock rates in Hz, 32 bit wide for the MFP accumulator
`define SYSTEM_CLOCK 32'd32_084_988
`define MFP_CLOCK    32'd2_457_600

// FIFO depths in bytes
`define MIDI_FIFO_DEPTH 16   // ACIA data writes
`define PAR_FIFO_DEPTH  4    // Printer port, small on purpose

// USB redirection codes, control word bits 27:26
// 0 nothing, 1 rs232, 2 printer, 3 midi
`define REDIR_PRINTER 2'd2

// Joystick word layout
// Bits 3:0 are the directions, bit 4 the fire button
`define JOY_FIRE_BIT 4

`endif

//--- st_io_pkg.sv
package st_io_pkg;

	// Target of the IO controller's USB redirection
	typedef enum logic [1:0] {
		redir_none    = 2'd0,
		redir_rs232   = 2'd1,
		redir_printer = 2'd2,
		redir_midi    = 2'd3
	} redirect_e;

	// IO controller control word
	// Reset, floppy write protect and scanline bits live in reserved_lo
	typedef struct packed {
		logic [1:0]  reserved_hi;  // 31:30
		logic        blend;        // 29
		logic        spare;        // 28, unassigned
		redirect_e   redirect;     // 27:26
		logic [25:0] reserved_lo;
	} sys_ctrl_t;

	// Which FIFO a host byte came from
	typedef enum logic {
		src_midi     = 1'b0,
		src_parallel = 1'b1
	} host_src_e;

	// One beat on the host stream
	typedef struct packed {
		host_src_e  src;
		logic [7:0] data;
	} host_byte_t;

endpackage

//--- mfp_clock_en.sv
`timescale 1ns/100ps

`include "st_io_consts.svh"

module mfp_clock_en (
	input  logic clk_32,
	input  logic reset,
	output logic mfp_en   // One clk_32 cycle per MFP tick
);

	// Fractional accumulator
	// Gains MFP_CLOCK per cycle, loses SYSTEM_CLOCK per pulse
	logic [31:0] acc;

	always_ff @(posedge clk_32) begin
		if (reset) begin
			acc    <= '0;
			mfp_en <= 1'b0;
		end else begin
			mfp_en <= 1'b0;   // Default low, single cycle pulse
			if (acc < `SYSTEM_CLOCK) begin
				acc <= acc + `MFP_CLOCK;
			end else begin
				// Wrap and keep the remainder so the average rate is exact
				acc    <= acc - `SYSTEM_CLOCK + `MFP_CLOCK;
				mfp_en <= 1'b1;
			end
		end
	end

	// Average pulse rate is 2.4576 MHz
	// The ratio is about 13, so pulses never touch

endmodule

//--- byte_fifo.sv
`timescale 1ns/100ps

module byte_fifo #(
	parameter int DEPTH = 16
) (
	input  logic       clk_32,
	input  logic       reset,
	input  logic       in_valid,
	output logic       in_ready,
	input  logic [7:0] in_data,
	output logic       out_valid,
	input  logic       out_ready,
	output logic [7:0] out_data,
	output logic       full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [7:0]    mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;       // Includes the output register
	logic [CW-1:0] mem_count;   // Bytes still in the array
	logic          push;
	logic          pop;
	logic          load;        // Array to output register

	assign in_ready  = (count != CW'(DEPTH));
	assign full      = ~in_ready;
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign mem_count = count - CW'(out_valid);

	// Refill output stage when empty or being drained
	assign load = (mem_count != '0) && (!out_valid || out_ready);

	always_ff @(posedge clk_32) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			out_valid <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (load)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			// Occupancy, push and pop may coincide
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			if (load)
				out_valid <= 1'b1;
			else if (pop)
				out_valid <= 1'b0;   // Drained, nothing behind it
		end
	end

	// Storage and output data
	always_ff @(posedge clk_32) begin
		if (push)
			mem[wr_ptr] <= in_data;
		if (load)
			out_data <= mem[rd_ptr];   // Held while back-pressured
	end

endmodule

//--- host_drain_fsm.sv
`timescale 1ns/100ps

module host_drain_fsm import st_io_pkg::*; (
	input  logic       clk_32,
	input  logic       reset,
	input  logic       midi_valid,   // MIDI FIFO head
	output logic       midi_ready,
	input  logic [7:0] midi_data,
	input  logic       par_valid,    // Parallel FIFO head
	output logic       par_ready,
	input  logic [7:0] par_data,
	output logic       host_valid,
	input  logic       host_ready,
	output host_byte_t host_beat
);

	typedef enum logic [1:0] {
		idle     = 2'd0,
		pop_midi = 2'd1,
		pop_par  = 2'd2,
		offer    = 2'd3
	} drain_state_e;

	drain_state_e state;
	drain_state_e state_nxt;
	host_src_e    last_served;
	logic         pick_midi;

	// Round robin when both are waiting
	always_comb begin
		if (midi_valid && par_valid)
			pick_midi = (last_served == src_parallel);
		else
			pick_midi = midi_valid;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (midi_valid || par_valid)
					state_nxt = pick_midi ? pop_midi : pop_par;
			end
			pop_midi: begin
				if (midi_valid)
					state_nxt = offer;
			end
			pop_par: begin
				if (par_valid)
					state_nxt = offer;
			end
			offer: begin
				if (host_ready)
					state_nxt = idle;   // Beat taken
			end
			default: state_nxt = idle;
		endcase
	end

	// Pops only happen in the pop states, never while offering
	assign midi_ready = (state == pop_midi);
	assign par_ready  = (state == pop_par);
	assign host_valid = (state == offer);

	always_ff @(posedge clk_32) begin
		if (reset) begin
			state       <= idle;
			last_served <= src_parallel;   // MIDI goes first
		end else begin
			state <= state_nxt;
			if (midi_ready && midi_valid)
				last_served <= src_midi;
			else if (par_ready && par_valid)
				last_served <= src_parallel;
		end
	end

	// Output register, held through the offer state
	always_ff @(posedge clk_32) begin
		if (midi_ready && midi_valid)
			host_beat <= '{src: src_midi, data: midi_data};
		else if (par_ready && par_valid)
			host_beat <= '{src: src_parallel, data: par_data};
	end

endmodule

//--- printer_port.sv
`timescale 1ns/100ps

`include "st_io_consts.svh"

module printer_port import st_io_pkg::*; (
	input  sys_ctrl_t   ctrl,
	input  logic        fifo_full,          // Parallel out FIFO
	input  logic [15:0] joy2,
	input  logic [15:0] joy3,
	output logic        printer_busy,
	output logic [7:0]  parallel_in,
	output logic        parallel_in_strobe
);

	logic redir_to_printer;

	// Low active directions, bit 0 ends up as the nibble's MSB
	function automatic logic [3:0] dir_nibble(input logic [15:0] joy);
		logic [3:0] nib;
		for (int i = 0; i < 4; i++)
			nib[3-i] = ~joy[i];
		return nib;
	endfunction

	assign redir_to_printer = (ctrl.redirect == redirect_e'(`REDIR_PRINTER));

	// Busy comes from the FIFO when the host takes the printer data
	// Otherwise the gauntlet adapter puts joy2 fire on the busy line
	assign printer_busy = redir_to_printer ? fifo_full : joy2[`JOY_FIRE_BIT];

	// Extra joysticks share the printer data lines
	assign parallel_in = {dir_nibble(joy2), dir_nibble(joy3)};

	assign parallel_in_strobe = ~joy3[`JOY_FIRE_BIT];   // joy3 fire, low active

endmodule

//--- st_io_bridge.sv
`timescale 1ns/100ps

`include "st_io_consts.svh"

module st_io_bridge import st_io_pkg::*; (
	input  logic        clk_32,
	input  logic        reset,
	input  sys_ctrl_t   ctrl,          // IO controller control word
	input  logic [15:0] joy2,
	input  logic [15:0] joy3,
	input  logic        midi_valid,    // ACIA data writes
	output logic        midi_ready,
	input  logic [7:0]  midi_data,
	input  logic        par_valid,     // Printer port writes
	output logic        par_ready,
	input  logic [7:0]  par_data,
	output logic        host_valid,    // Merged stream to the host
	input  logic        host_ready,
	output host_byte_t  host_beat,
	output logic        mfp_en,
	output logic        printer_busy,
	output logic [7:0]  parallel_in,
	output logic        parallel_in_strobe
);

	// FIFO heads towards the drain FSM
	logic       midi_q_valid;
	logic       midi_q_ready;
	logic [7:0] midi_q_data;
	logic       par_q_valid;
	logic       par_q_ready;
	logic [7:0] par_q_data;
	logic       par_full;

	mfp_clock_en u_mfp_clk (
		.clk_32 (clk_32),
		.reset  (reset),
		.mfp_en (mfp_en)
	);

	byte_fifo #(.DEPTH(`MIDI_FIFO_DEPTH)) u_midi_fifo (
		.clk_32    (clk_32),
		.reset     (reset),
		.in_valid  (midi_valid),
		.in_ready  (midi_ready),
		.in_data   (midi_data),
		.out_valid (midi_q_valid),
		.out_ready (midi_q_ready),
		.out_data  (midi_q_data),
		.full      ()
	);

	byte_fifo #(.DEPTH(`PAR_FIFO_DEPTH)) u_par_fifo (
		.clk_32    (clk_32),
		.reset     (reset),
		.in_valid  (par_valid),
		.in_ready  (par_ready),
		.in_data   (par_data),
		.out_valid (par_q_valid),
		.out_ready (par_q_ready),
		.out_data  (par_q_data),
		.full      (par_full)       // Printer busy source
	);

	host_drain_fsm u_drain (
		.clk_32     (clk_32),
		.reset      (reset),
		.midi_valid (midi_q_valid),
		.midi_ready (midi_q_ready),
		.midi_data  (midi_q_data),
		.par_valid  (par_q_valid),
		.par_ready  (par_q_ready),
		.par_data   (par_q_data),
		.host_valid (host_valid),
		.host_ready (host_ready),
		.host_beat  (host_beat)
	);

	printer_port u_printer (
		.ctrl               (ctrl),
		.fifo_full          (par_full),
		.joy2               (joy2),
		.joy3               (joy3),
		.printer_busy       (printer_busy),
		.parallel_in        (parallel_in),
		.parallel_in_strobe (parallel_in_strobe)
	);

endmodule

//--- st_io_bridge_sva.sv
`timescale 1ns/100ps

module st_io_bridge_sva import st_io_pkg::*; (
	input logic       clk_32,
	input logic       reset,
	input sys_ctrl_t  ctrl,
	input logic       mfp_en,
	input logic       par_ready,
	input logic       printer_busy,
	input logic       host_valid,
	input logic       host_ready,
	input host_byte_t host_beat
);

	// Single cycle enable, never back to back
	mfp_single_pulse: assert property (@(posedge clk_32) disable iff (reset)
		mfp_en |=> !mfp_en)
		else $error("mfp_en high in two consecutive cycles");

	// Offered beat held until the host takes it
	host_beat_held: assert property (@(posedge clk_32) disable iff (reset)
		(host_valid && !host_ready) |=> (host_valid && $stable(host_beat)))
		else $error("host beat changed or dropped before host_ready");

	// Busy printer means the FIFO takes nothing
	busy_blocks_par: assert property (@(posedge clk_32) disable iff (reset)
		(printer_busy && ctrl.redirect == redir_printer) |-> !par_ready)
		else $error("par_ready high while the printer reports busy");

endmodule

//--- st_io_bridge_tb.sv
`timescale 1ns/100ps

`include "st_io_consts.svh"

module st_io_bridge_tb import st_io_pkg::*; ();

	localparam int MFP_CYCLES = 20000;
	localparam int N_MIDI     = 48;
	localparam int N_PAR      = 24;
	localparam int N_SAT      = 20;   // Per source in the round robin test
	localparam int N_JOY      = 64;
	localparam int WATCHDOG_CYCLES = MFP_CYCLES + 12 * (N_MIDI + N_PAR + 2 * N_SAT)
		+ 2 * N_JOY + 400;

	logic        clk_32;
	logic        reset;
	sys_ctrl_t   ctrl;
	logic [15:0] joy2;
	logic [15:0] joy3;
	logic        midi_valid;
	logic        midi_ready;
	logic [7:0]  midi_data;
	logic        par_valid;
	logic        par_ready;
	logic [7:0]  par_data;
	logic        host_valid;
	logic        host_ready;
	host_byte_t  host_beat;
	logic        mfp_en;
	logic        printer_busy;
	logic [7:0]  parallel_in;
	logic        parallel_in_strobe;

	int          errors;
	int          checks;
	int          hr_mode;      // 0 host stalls, 1 always ready, 2 random stalls
	logic [31:0] rng_midi;     // One generator per stream
	logic [31:0] rng_par;
	logic [31:0] rng_host;
	logic [31:0] rng_joy;
	logic [7:0]  exp_midi[$];  // Bytes sent and not yet seen on the host side
	logic [7:0]  exp_par[$];
	logic [31:0] model_acc;
	logic        model_en;
	logic        alt_check;
	int          alt_count;
	host_src_e   prev_src;

	st_io_bridge i_dut (.*);

	bind st_io_bridge st_io_bridge_sva u_sva (
		.clk_32       (clk_32),
		.reset        (reset),
		.ctrl         (ctrl),
		.mfp_en       (mfp_en),
		.par_ready    (par_ready),
		.printer_busy (printer_busy),
		.host_valid   (host_valid),
		.host_ready   (host_ready),
		.host_beat    (host_beat)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Returns {pulse, next accumulator}
	// A wrap costs one system clock worth
	function automatic logic [32:0] mfp_ref(input logic [31:0] acc);
		if (acc < `SYSTEM_CLOCK)
			return {1'b0, acc + `MFP_CLOCK};
		return {1'b1, acc - `SYSTEM_CLOCK + `MFP_CLOCK};
	endfunction

	// {printer_busy, parallel_in, parallel_in_strobe}
	function automatic logic [9:0] printer_ref(input logic [15:0] j2, input logic [15:0] j3,
			input redirect_e redir, input logic fifo_full);
		logic       busy;
		logic [7:0] pin;
		busy = (redir == redirect_e'(`REDIR_PRINTER)) ? fifo_full : j2[`JOY_FIRE_BIT];
		pin  = ~{j2[0], j2[1], j2[2], j2[3], j3[0], j3[1], j3[2], j3[3]};   // Bit 0 on top
		return {busy, pin, ~j3[`JOY_FIRE_BIT]};
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		checks++;
		if (got !== want) begin
			$display("FAIL %0t: %s byte %h on host stream, expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic report_extra(input string name, input logic [7:0] got);
		$display("Host stream delivered a %s byte %h that was never sent, at %0t",
			name, got, $time);
		errors++;
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		$display("Test %0d %s finished with %0d errors", num, name, errors - err_before);
	endtask

	// Offer bytes with random idle gaps and hold valid until accepted
	task automatic send_midi(input int count, input int max_gap);
		int gap;
		for (int i = 0; i < count; i++) begin
			@(posedge clk_32);
			rng_midi = xorshift(rng_midi);
			midi_valid <= 1'b1;
			midi_data  <= rng_midi[7:0];
			gap = (max_gap > 0) ? int'(rng_midi[15:8]) % (max_gap + 1) : 0;
			@(negedge clk_32);
			while (!midi_ready)
				@(negedge clk_32);
			exp_midi.push_back(midi_data);   // Transfers on the next edge
			if (gap > 0) begin
				@(posedge clk_32);
				midi_valid <= 1'b0;
				repeat (gap - 1) @(posedge clk_32);
			end
		end
		@(posedge clk_32);
		midi_valid <= 1'b0;
	endtask

	task automatic send_par(input int count, input int max_gap);
		int gap;
		for (int i = 0; i < count; i++) begin
			@(posedge clk_32);
			rng_par = xorshift(rng_par);
			par_valid <= 1'b1;
			par_data  <= rng_par[7:0];
			gap = (max_gap > 0) ? int'(rng_par[15:8]) % (max_gap + 1) : 0;
			@(negedge clk_32);
			while (!par_ready)
				@(negedge clk_32);
			exp_par.push_back(par_data);
			if (gap > 0) begin
				@(posedge clk_32);
				par_valid <= 1'b0;
				repeat (gap - 1) @(posedge clk_32);
			end
		end
		@(posedge clk_32);
		par_valid <= 1'b0;
	endtask

	// Scoreboard pops at the falling edge, so checked here on the rising one
	task automatic wait_drain();
		while (exp_midi.size() != 0 || exp_par.size() != 0)
			@(posedge clk_32);
	endtask

	initial clk_32 = 1'b0;
	always #10 clk_32 = ~clk_32;

	// MFP accumulator model stepped by the reference function
	always @(posedge clk_32) begin
		if (reset) begin
			model_acc <= '0;
			model_en  <= 1'b0;
		end else begin
			{model_en, model_acc} <= mfp_ref(model_acc);
		end
	end

	// Host side back-pressure
	always @(posedge clk_32) begin
		case (hr_mode)
			0: host_ready <= 1'b0;
			1: host_ready <= 1'b1;
			default: begin
				rng_host = xorshift(rng_host);
				host_ready <= (rng_host[1:0] != 2'd0);   // Ready 3 of 4 cycles
			end
		endcase
	end

	// Host beats compared against the per-source queues
	always @(negedge clk_32) begin
		if (!reset && host_valid && host_ready) begin
			if (alt_check) begin
				checks++;
				if (alt_count == 0 && host_beat.src != src_midi) begin
					$display("FAIL %0t: first beat after reset is not MIDI", $time);
					errors++;
				end else if (alt_count != 0 && host_beat.src == prev_src) begin
					$display("FAIL %0t: beat %0d repeats the previous source", $time, alt_count);
					errors++;
				end
				prev_src = host_beat.src;
				alt_count++;
			end
			if (host_beat.src == src_midi) begin
				if (exp_midi.size() == 0)
					report_extra("MIDI", host_beat.data);
				else
					check_byte("MIDI", host_beat.data, exp_midi.pop_front());
			end else begin
				if (exp_par.size() == 0)
					report_extra("parallel", host_beat.data);
				else
					check_byte("parallel", host_beat.data, exp_par.pop_front());
			end
		end
	end

	initial begin
		int         test_err;
		int         pulses_dut;
		int         pulses_ref;
		int         accepted;
		logic [9:0] want;
		reset      = 1'b1;
		ctrl       = '0;   // Redirect none
		joy2       = '0;
		joy3       = '0;
		midi_valid = 1'b0;
		midi_data  = '0;
		par_valid  = 1'b0;
		par_data   = '0;
		host_ready = 1'b0;
		errors     = 0;
		checks     = 0;
		hr_mode    = 0;
		alt_check  = 1'b0;
		alt_count  = 0;
		prev_src   = src_parallel;
		rng_midi   = xorshift(32'd98437);
		rng_par    = xorshift(rng_midi);
		rng_host   = xorshift(rng_par);
		rng_joy    = xorshift(rng_host);
		repeat (3) @(posedge clk_32);
		reset <= 1'b0;

		// MFP enable against the accumulator model
		test_err   = errors;
		pulses_dut = 0;
		pulses_ref = 0;
		repeat (MFP_CYCLES) begin
			@(negedge clk_32);
			checks++;
			if (mfp_en !== model_en) begin
				$display("FAIL %0t: mfp_en is %b, model expects %b", $time, mfp_en, model_en);
				errors++;
			end
			if (mfp_en)
				pulses_dut++;
			if (model_en)
				pulses_ref++;
		end
		checks++;
		if (pulses_dut != pulses_ref) begin
			$display("FAIL %0t: %0d MFP pulses, model gives %0d", $time, pulses_dut, pulses_ref);
			errors++;
		end
		report_test(1, "MFP clock enable", test_err);

		test_err = errors;
		hr_mode  = 2;
		send_midi(N_MIDI, 3);
		wait_drain();
		report_test(2, "MIDI to host", test_err);

		// Parallel bytes first and then a fill against a stalled host
		test_err = errors;
		send_par(N_PAR, 3);
		wait_drain();
		@(negedge clk_32);
		hr_mode = 0;
		@(posedge clk_32);
		ctrl.redirect <= redir_printer;
		rng_par = xorshift(rng_par);
		par_valid <= 1'b1;
		par_data  <= rng_par[7:0];
		accepted = 0;
		@(negedge clk_32);
		while (par_ready && accepted < 2 * `PAR_FIFO_DEPTH) begin
			checks++;
			if (printer_busy) begin
				$display("FAIL %0t: printer_busy high while the FIFO accepts", $time);
				errors++;
			end
			exp_par.push_back(par_data);
			accepted++;
			@(posedge clk_32);
			rng_par = xorshift(rng_par);
			par_data <= rng_par[7:0];
			@(negedge clk_32);
		end
		checks++;
		if (accepted != `PAR_FIFO_DEPTH + 1) begin
			$display("FAIL %0t: par_ready dropped after %0d bytes, expected %0d",
				$time, accepted, `PAR_FIFO_DEPTH + 1);
			errors++;
		end
		repeat (8) begin   // Must stay full while the host stalls
			checks++;
			if (par_ready || !printer_busy) begin
				$display("FAIL %0t: par_ready %b printer_busy %b with a stalled host",
					$time, par_ready, printer_busy);
				errors++;
			end
			@(negedge clk_32);
		end
		hr_mode = 2;
		while (!par_ready)
			@(negedge clk_32);
		exp_par.push_back(par_data);
		@(posedge clk_32);
		par_valid     <= 1'b0;
		ctrl.redirect <= redir_none;
		wait_drain();
		report_test(3, "parallel to host", test_err);

		// Both sources saturated from a fresh reset
		test_err = errors;
		@(negedge clk_32);
		hr_mode   = 1;
		alt_count = 0;
		alt_check = 1'b1;
		@(posedge clk_32);
		reset <= 1'b1;
		repeat (3) @(posedge clk_32);
		reset <= 1'b0;
		fork
			send_midi(N_SAT, 0);
			send_par(N_SAT, 0);
		join
		wait_drain();
		alt_check = 1'b0;
		checks++;
		if (alt_count != 2 * N_SAT) begin
			$display("FAIL %0t: %0d beats seen, expected %0d", $time, alt_count, 2 * N_SAT);
			errors++;
		end
		report_test(4, "round robin", test_err);

		test_err = errors;
		repeat (N_JOY) begin
			@(posedge clk_32);
			rng_joy = xorshift(rng_joy);
			joy2 <= rng_joy[15:0];
			joy3 <= rng_joy[31:16];
			@(negedge clk_32);
			// Parallel FIFO is empty once the round robin test has drained
			want = printer_ref(joy2, joy3, ctrl.redirect, 1'b0);
			checks++;
			if ({printer_busy, parallel_in, parallel_in_strobe} !== want) begin
				$display("FAIL %0t: joy2 %h joy3 %h gave busy %b in %h strobe %b, expected %h",
					$time, joy2, joy3, printer_busy, parallel_in, parallel_in_strobe, want);
				errors++;
			end
		end
		report_test(5, "printer port mapping", test_err);

		$display("Tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_32);
		$display("Watchdog expired after %0d cycles, %0d MIDI and %0d parallel bytes lost",
			WATCHDOG_CYCLES, exp_midi.size(), exp_par.size());
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- st_io_bridge.f
+incdir+.
st_io_pkg.sv
mfp_clock_en.sv
byte_fifo.sv
host_drain_fsm.sv
printer_port.sv
st_io_bridge.sv
st_io_bridge_sva.sv
st_io_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module st_io_bridge_tb \
	-f st_io_bridge.f -o st_io_sim &&
./obj_dir/st_io_sim | tee /dev/stderr | grep -qx '>>> PASS' &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed" >&2; exit 1; }
